// ==== decode_stage.f ====
verilog/rv_pkg.sv
verilog/id_control.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/decode_stage.sv
testbench/decode_stage_assertions.sv
testbench/decode_stage_tb.sv

// ==== testbench/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;

    // Cycles taken by all test tasks together
    localparam int test_cycles    = 50;
    localparam int timeout_cycles = 2 * test_cycles;

    logic               clk;
    logic               rst;
    logic [31:0]        inst;
    logic [31:0]        pc;
    logic [31:0]        ex_fp_inst;
    logic               fpu_busy;
    rv_pkg::reg_write_s x_wb;
    rv_pkg::reg_write_s f_wb;
    rv_pkg::id_ex_s     id_ex;
    logic               hold;

    integer      seed;
    int          cycles = 0;
    logic [31:0] x_model [32];
    logic [31:0] f_model [32];

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .pc         (pc),
        .ex_fp_inst (ex_fp_inst),
        .fpu_busy   (fpu_busy),
        .x_wb       (x_wb),
        .f_wb       (f_wb),
        .id_ex      (id_ex),
        .hold       (hold)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    // Instruction encoders
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s = 0x%h, expected 0x%h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic issue(input logic [31:0] inst_v, input logic [31:0] pc_v);
        inst = inst_v;
        pc   = pc_v;
        #2;
    endtask

    task automatic check_bubble();
        check_value("id_ex.valid", id_ex.valid, 1'b0);
        check_value("id_ex.fpu_valid", id_ex.fpu_valid, 1'b0);
        check_value("id_ex.inst", id_ex.inst, rv_pkg::nop_inst);
    endtask

    task automatic check_loaded(input logic [31:0] inst_v, input logic [31:0] pc_v);
        check_value("id_ex.valid", id_ex.valid, 1'b1);
        check_value("id_ex.inst", id_ex.inst, inst_v);
        check_value("id_ex.pc", id_ex.pc, pc_v);
    endtask

    task automatic check_reads(input logic [4:0] a1, input logic [4:0] a2,
            input logic [4:0] a3);
        check_value("id_ex.rs1_val", id_ex.rs1_val, x_model[a1]);
        check_value("id_ex.rs2_val", id_ex.rs2_val, x_model[a2]);
        check_value("id_ex.fs1_val", id_ex.fs1_val, f_model[a1]);
        check_value("id_ex.fs2_val", id_ex.fs2_val, f_model[a2]);
        check_value("id_ex.fs3_val", id_ex.fs3_val, f_model[a3]);
    endtask

    task automatic test_reset();
        rst = 1'b1;
        for (int i = 0; i < 32; i++) begin
            x_model[i] = '0;
            f_model[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        #2;
        check_value("hold", hold, 1'b0);
        check_bubble();
        @(negedge clk);
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] exp;
        for (int fmt = 0; fmt < 6; fmt++) begin
            r = $random(seed);
            case (fmt)
                0: begin
                    word = itype_word(r[11:0], r[19:15], 3'b000, 5'd0, rv_pkg::opc_ari_itype);
                    exp  = {{20{r[11]}}, r[11:0]};
                end
                1: begin
                    word = stype_word(r[11:0], r[24:20], r[19:15], 3'b010, rv_pkg::opc_store);
                    exp  = {{20{r[11]}}, r[11:0]};
                end
                2: begin
                    word = {r[12], r[10:5], r[24:20], r[19:15], 3'b000, r[4:1], r[11],
                        rv_pkg::opc_branch};
                    exp  = {{19{r[12]}}, r[12:1], 1'b0};
                end
                3: begin
                    word = {r[20], r[10:1], r[11], r[19:12], 5'd0, rv_pkg::opc_jal};
                    exp  = {{11{r[20]}}, r[20:1], 1'b0};
                end
                4: begin
                    word = {r[31:12], 5'd0, rv_pkg::opc_lui};
                    exp  = {r[31:12], 12'd0};
                end
                default: begin
                    // CSRRWI, uimm in the rs1 field
                    word = {r[31:20], r[19:15], 3'b101, 5'd0, rv_pkg::opc_csr};
                    exp  = {27'd0, r[19:15]};
                end
            endcase
            issue(word, 32'h1000 + fmt * 4);
            check_value("hold", hold, 1'b0);
            @(negedge clk);
            check_loaded(word, 32'h1000 + fmt * 4);
            check_value("id_ex.imm", id_ex.imm, exp);
        end
    endtask

    task automatic test_registers();
        logic [4:0]  addr [6];
        logic [31:0] xd;
        logic [31:0] fd;
        logic [31:0] word;
        for (int k = 0; k < 6; k++) begin
            xd      = $random(seed);
            addr[k] = (k == 0) ? 5'd0 : xd[31:27];
            fd      = $random(seed);
            x_wb    = '{en: 1'b1, addr: addr[k], data: xd};
            f_wb    = '{en: 1'b1, addr: addr[k], data: fd};
            if (addr[k] != 5'd0) begin
                x_model[addr[k]] = xd;
            end
            f_model[addr[k]] = fd;
            @(negedge clk);
        end
        x_wb = '0;
        f_wb = '0;
        for (int k = 0; k < 6; k++) begin
            word = rtype_word({addr[(k + 2) % 6], 2'b00}, addr[(k + 1) % 6], addr[k], 3'b000,
                5'd0, rv_pkg::opc_fp_madd);
            issue(word, 32'h2000 + k * 4);
            @(negedge clk);
            check_reads(addr[k], addr[(k + 1) % 6], addr[(k + 2) % 6]);
        end
        // Write and read of one register in the same cycle
        xd      = $random(seed);
        fd      = $random(seed);
        addr[0] = xd[4:0] | 5'd1;
        x_wb    = '{en: 1'b1, addr: addr[0], data: xd};
        f_wb    = '{en: 1'b1, addr: addr[0], data: fd};
        x_model[addr[0]] = xd;
        f_model[addr[0]] = fd;
        word = rtype_word({addr[0], 2'b00}, addr[0], addr[0], 3'b000, 5'd0,
            rv_pkg::opc_fp_madd);
        issue(word, 32'h2100);
        @(negedge clk);
        x_wb = '0;
        f_wb = '0;
        check_reads(addr[0], addr[0], addr[0]);
    endtask

    task automatic run_pair(input logic [31:0] producer, input logic [31:0] consumer,
            input logic stalls);
        issue(producer, 32'h3000);
        check_value("hold", hold, 1'b0);
        @(negedge clk);
        check_loaded(producer, 32'h3000);
        issue(consumer, 32'h3004);
        check_value("hold", hold, stalls);
        if (stalls) begin
            @(negedge clk);
            check_bubble();
            check_value("hold", hold, 1'b0);
        end
        @(negedge clk);
        check_loaded(consumer, 32'h3004);
    endtask

    task automatic test_int_hazards();
        run_pair(rtype_word(7'd0, 5'd2, 5'd1, 3'b000, 5'd5, rv_pkg::opc_ari_rtype),
            itype_word(12'd1, 5'd5, 3'b000, 5'd6, rv_pkg::opc_ari_itype), 1'b1);
        run_pair(rtype_word(7'd0, 5'd4, 5'd3, 3'b000, 5'd5, rv_pkg::opc_ari_rtype),
            rtype_word(7'd0, 5'd5, 5'd3, 3'b000, 5'd8, rv_pkg::opc_ari_rtype), 1'b1);
        run_pair(itype_word(12'd5, 5'd1, 3'b000, 5'd0, rv_pkg::opc_ari_itype),
            stype_word(12'd0, 5'd0, 5'd0, 3'b010, rv_pkg::opc_store), 1'b0);
        // LUI with x5 in the bits where rs1 would sit
        run_pair(rtype_word(7'd0, 5'd2, 5'd1, 3'b000, 5'd5, rv_pkg::opc_ari_rtype),
            {20'h00028, 5'd7, rv_pkg::opc_lui}, 1'b0);
    endtask

    task automatic test_fp_hazards();
        logic [31:0] fsw;
        fsw = stype_word(12'd12, 5'd7, 5'd0, 3'b010, rv_pkg::opc_fp_store);
        run_pair(itype_word(12'd8, 5'd1, 3'b010, 5'd3, rv_pkg::opc_fp_load),
            rtype_word({5'd3, 2'b00}, 5'd2, 5'd1, 3'b000, 5'd4, rv_pkg::opc_fp_madd), 1'b1);
        ex_fp_inst = rtype_word(rv_pkg::fnc7_fp_add, 5'd1, 5'd2, 3'b000, 5'd7, rv_pkg::opc_fp);
        issue(fsw, 32'h4000);
        check_value("hold", hold, 1'b1);
        repeat (3) begin
            @(negedge clk);
            check_bubble();
            check_value("hold", hold, 1'b1);
        end
        ex_fp_inst = rv_pkg::nop_inst;
        #2;
        check_value("hold", hold, 1'b0);
        @(negedge clk);
        check_loaded(fsw, 32'h4000);
        ex_fp_inst = rtype_word(rv_pkg::fnc7_fp_mv_x_w, 5'd0, 5'd7, 3'b000, 5'd7,
            rv_pkg::opc_fp);
        issue(fsw, 32'h4004);
        check_value("hold", hold, 1'b0);
        @(negedge clk);
        check_loaded(fsw, 32'h4004);
        ex_fp_inst = rv_pkg::nop_inst;
    endtask

    task automatic test_fpu_busy();
        logic [31:0] fsw;
        logic [31:0] fadd;
        fsw  = stype_word(12'd12, 5'd7, 5'd0, 3'b010, rv_pkg::opc_fp_store);
        fadd = rtype_word(rv_pkg::fnc7_fp_add, 5'd2, 5'd1, 3'b000, 5'd9, rv_pkg::opc_fp);
        fpu_busy = 1'b1;
        issue(fadd, 32'h5000);
        check_value("hold", hold, 1'b1);
        repeat (3) begin
            @(negedge clk);
            // FSW from the FP hazard test stays in EX
            check_loaded(fsw, 32'h4004);
            check_value("id_ex.fpu_valid", id_ex.fpu_valid, 1'b0);
            check_value("hold", hold, 1'b1);
        end
        fpu_busy = 1'b0;
        #2;
        check_value("hold", hold, 1'b0);
        @(negedge clk);
        check_loaded(fadd, 32'h5000);
        check_value("id_ex.fpu_valid", id_ex.fpu_valid, 1'b1);
        check_value("id_ex.fs1_val", id_ex.fs1_val, f_model[1]);
        check_value("id_ex.fs2_val", id_ex.fs2_val, f_model[2]);
    endtask

    initial begin
        seed       = 32'h776dbc65;
        rst        = 1'b1;
        inst       = rv_pkg::nop_inst;
        pc         = '0;
        ex_fp_inst = rv_pkg::nop_inst;
        fpu_busy   = 1'b0;
        x_wb       = '0;
        f_wb       = '0;
        test_reset();
        test_immediates();
        test_registers();
        test_int_hazards();
        test_fp_hazards();
        test_fpu_busy();
        if (i_decode_stage.i_assertions.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d concurrent assertion failures",
                i_decode_stage.i_assertions.fail_count);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== testbench/decode_stage_assertions.sv ====
`timescale 1ns/1ps

module decode_stage_assertions (
    input logic           clk,
    input logic           rst,
    input logic           hold,
    input rv_pkg::id_ex_s id_ex
);

    int unsigned fail_count = 0;

    // While hold is high ID/EX keeps its value or takes a bubble
    property hold_keeps_or_bubbles;
        @(posedge clk) disable iff (rst)
        hold |=> (id_ex == $past(id_ex))
            || (!id_ex.valid && !id_ex.fpu_valid && id_ex.inst == rv_pkg::nop_inst);
    endproperty

    assert_hold: assert property (hold_keeps_or_bubbles)
        else begin
            fail_count++;
            $error("ID/EX took a new instruction while hold was high");
        end

    assert_reset: assert property (@(posedge clk) rst |=> !id_ex.valid)
        else begin
            fail_count++;
            $error("ID/EX valid high in the cycle after reset");
        end

    assert_fpu: assert property (@(posedge clk) disable iff (rst)
        id_ex.fpu_valid |-> id_ex.valid)
        else begin
            fail_count++;
            $error("ID/EX fpu_valid high without valid");
        end

endmodule

bind decode_stage decode_stage_assertions i_assertions (
    .clk   (clk),
    .rst   (rst),
    .hold  (hold),
    .id_ex (id_ex)
);

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        inst,
    input  logic [31:0]        pc,
    input  logic [31:0]        ex_fp_inst,
    input  logic               fpu_busy,
    input  rv_pkg::reg_write_s x_wb,
    input  rv_pkg::reg_write_s f_wb,

    output rv_pkg::id_ex_s     id_ex,
    output logic               hold
);

    localparam rv_pkg::id_ex_s id_ex_bubble = '{inst: rv_pkg::nop_inst, default: '0};

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] fs1;
    logic [4:0] fs2;
    logic [4:0] fs3;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign fs1 = inst[19:15];
    assign fs2 = inst[24:20];
    assign fs3 = inst[31:27];

    rv_pkg::imm_sel_e imm_sel;
    logic             stall;
    logic             id_ex_stall;
    logic             fpu_valid;
    logic [31:0]      imm;

    rv_pkg::xword_t   rs1_val;
    rv_pkg::xword_t   rs2_val;
    rv_pkg::fword_t   fs1_val;
    rv_pkg::fword_t   fs2_val;
    rv_pkg::fword_t   fs3_val;

    id_control i_id_control (
        .inst        (inst),
        .ex_inst     (id_ex.inst),
        .ex_fp_inst  (ex_fp_inst),
        .fpu_busy    (fpu_busy),
        .imm_sel     (imm_sel),
        .stall       (stall),
        .id_ex_stall (id_ex_stall),
        .fpu_valid   (fpu_valid)
    );

    imm_gen i_imm_gen (
        .inst    (inst),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    // Integer file has only two read ports in use
    reg_file #(
        .data_t    (rv_pkg::xword_t),
        .hard_zero (1'b1)
    ) x_regs (
        .clk (clk),
        .rst (rst),
        .wr  (x_wb),
        .ra1 (rs1),
        .ra2 (rs2),
        .ra3 (5'd0),
        .rd1 (rs1_val),
        .rd2 (rs2_val),
        .rd3 ()
    );

    reg_file #(
        .data_t    (rv_pkg::fword_t),
        .hard_zero (1'b0)
    ) f_regs (
        .clk (clk),
        .rst (rst),
        .wr  (f_wb),
        .ra1 (fs1),
        .ra2 (fs2),
        .ra3 (fs3),
        .rd1 (fs1_val),
        .rd2 (fs2_val),
        .rd3 (fs3_val)
    );

    rv_pkg::id_ex_s id_ex_next;

    always_comb begin
        id_ex_next.valid     = 1'b1;
        id_ex_next.fpu_valid = fpu_valid;
        id_ex_next.inst      = inst;
        id_ex_next.pc        = pc;
        id_ex_next.rs1_val   = rs1_val;
        id_ex_next.rs2_val   = rs2_val;
        id_ex_next.fs1_val   = fs1_val;
        id_ex_next.fs2_val   = fs2_val;
        id_ex_next.fs3_val   = fs3_val;
        id_ex_next.imm       = imm;
    end

    // FPU back-pressure freezes ID/EX, a data hazard sends a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= id_ex_bubble;
        end else if (id_ex_stall) begin
            id_ex <= id_ex;
        end else if (stall) begin
            id_ex <= id_ex_bubble;
        end else begin
            id_ex <= id_ex_next;
        end
    end

    assign hold = stall || id_ex_stall;

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter type data_t    = logic [31:0],
    parameter bit  hard_zero = 1'b0
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::reg_write_s wr,
    input  logic [4:0]         ra1,
    input  logic [4:0]         ra2,
    input  logic [4:0]         ra3,
    output data_t              rd1,
    output data_t              rd2,
    output data_t              rd3
);

    data_t regs [32];
    logic  wr_ok;

    // x0 never takes a write in the integer file
    assign wr_ok = wr.en && !(hard_zero && wr.addr == 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr.addr] <= data_t'(wr.data);
        end
    end

    // Write-through so a same-cycle read sees the new value
    function automatic data_t read_port(input logic [4:0] ra);
        data_t val;
        if (hard_zero && ra == 5'd0) begin
            val = '0;
        end else if (wr_ok && wr.addr == ra) begin
            val = data_t'(wr.data);
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
        rd3 = read_port(ra3);
    end

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:0]      inst,
    input  rv_pkg::imm_sel_e imm_sel,
    output logic [31:0]      imm
);

    logic        sign;
    logic [31:0] imm_i_val;
    logic [31:0] imm_s_val;
    logic [31:0] imm_b_val;
    logic [31:0] imm_j_val;
    logic [31:0] imm_u_val;
    logic [31:0] imm_csr_val;

    assign sign = inst[31];

    assign imm_i_val = {{20{sign}}, inst[31:20]};
    assign imm_s_val = {{20{sign}}, inst[31:25], inst[11:7]};

    // Branch and jump offsets are halfword aligned
    assign imm_b_val = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j_val = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign imm_u_val = {inst[31:12], 12'b0};

    // uimm sits in the rs1 field
    assign imm_csr_val = {27'b0, inst[19:15]};

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_i:   imm = imm_i_val;
            rv_pkg::imm_s:   imm = imm_s_val;
            rv_pkg::imm_b:   imm = imm_b_val;
            rv_pkg::imm_j:   imm = imm_j_val;
            rv_pkg::imm_u:   imm = imm_u_val;
            rv_pkg::imm_csr: imm = imm_csr_val;
            default:         imm = 32'b0;
        endcase
    end

endmodule

// ==== verilog/id_control.sv ====
`timescale 1ns/1ps

module id_control (
    input  logic [31:0]      inst,
    input  logic [31:0]      ex_inst,
    input  logic [31:0]      ex_fp_inst,
    input  logic             fpu_busy,

    output rv_pkg::imm_sel_e imm_sel,
    output logic             stall,
    output logic             id_ex_stall,
    output logic             fpu_valid
);

    logic [6:0] op;
    logic [4:0] opcode5;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] ex_op;
    logic [6:0] ex_funct7;
    logic [6:0] fpu_op;
    logic [6:0] fpu_funct7;

    assign op         = inst[6:0];
    assign opcode5    = inst[6:2];
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign ex_op      = ex_inst[6:0];
    assign ex_funct7  = ex_inst[31:25];
    assign fpu_op     = ex_fp_inst[6:0];
    assign fpu_funct7 = ex_fp_inst[31:25];

    // Integer sources actually read by the decoded instruction
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign has_rs1 = op != rv_pkg::opc_lui && op != rv_pkg::opc_auipc
        && op != rv_pkg::opc_jal && op != rv_pkg::opc_fp_madd
        && (op != rv_pkg::opc_csr || funct3 == rv_pkg::fnc_csrrw)
        && (op != rv_pkg::opc_fp || funct7 == rv_pkg::fnc7_fp_mv_w_x
            || funct7 == rv_pkg::fnc7_fp_cvt_s_w)
        && rs1 != 5'd0;

    assign has_rs2 = (op == rv_pkg::opc_ari_rtype || op == rv_pkg::opc_store
        || op == rv_pkg::opc_branch) && rs2 != 5'd0;

    // FP sources, f0 is an ordinary register
    logic [4:0] fs1;
    logic [4:0] fs2;
    logic [4:0] fs3;
    logic       has_fs1;
    logic       has_fs2;
    logic       has_fs3;
    logic       fp_two_src;

    assign fs1 = inst[19:15];
    assign fs2 = inst[24:20];
    assign fs3 = inst[31:27];

    assign fp_two_src = op == rv_pkg::opc_fp
        && (funct7 == rv_pkg::fnc7_fp_add || funct7 == rv_pkg::fnc7_fp_fsgnj_s);

    assign has_fs1 = op == rv_pkg::opc_fp_madd || fp_two_src
        || (op == rv_pkg::opc_fp && funct7 == rv_pkg::fnc7_fp_mv_x_w);
    assign has_fs2 = op == rv_pkg::opc_fp_store || op == rv_pkg::opc_fp_madd || fp_two_src;
    assign has_fs3 = op == rv_pkg::opc_fp_madd;

    // Destinations of the EX instruction and of the FPU instruction
    logic [4:0] ex_rd;
    logic       ex_has_rd;
    logic       ex_has_fd;
    logic [4:0] fpu_fd;
    logic       fpu_has_fd;

    assign ex_rd = ex_inst[11:7];

    assign ex_has_rd = ex_op != rv_pkg::opc_store && ex_op != rv_pkg::opc_branch
        && ex_op != rv_pkg::opc_csr && ex_op != rv_pkg::opc_fp_load
        && ex_op != rv_pkg::opc_fp_store && ex_op != rv_pkg::opc_fp_madd
        && (ex_op != rv_pkg::opc_fp || ex_funct7 == rv_pkg::fnc7_fp_mv_x_w);

    // Only FLW writes the FP file from EX, the rest go through the FPU
    assign ex_has_fd = ex_op == rv_pkg::opc_fp_load;

    assign fpu_fd     = ex_fp_inst[11:7];
    assign fpu_has_fd = fpu_op == rv_pkg::opc_fp_madd
        || (fpu_op == rv_pkg::opc_fp && fpu_funct7 != rv_pkg::fnc7_fp_mv_x_w);

    function automatic logic fp_src_match(input logic [4:0] fd);
        return (has_fs1 && fs1 == fd) || (has_fs2 && fs2 == fd) || (has_fs3 && fs3 == fd);
    endfunction

    logic x_hazard;
    logic f_hazard;
    logic fpu_inst;

    assign x_hazard = ex_has_rd && ((has_rs1 && rs1 == ex_rd) || (has_rs2 && rs2 == ex_rd));

    always_comb begin
        f_hazard = (ex_has_fd && fp_src_match(ex_rd))
            || (fpu_has_fd && fp_src_match(fpu_fd));
    end

    assign fpu_inst = op == rv_pkg::opc_fp || op == rv_pkg::opc_fp_madd;

    assign stall       = x_hazard || f_hazard;
    assign id_ex_stall = fpu_busy && fpu_inst;
    assign fpu_valid   = fpu_inst && !fpu_busy;

    always_comb begin
        case (opcode5)
            rv_pkg::opc_ari_itype[6:2]: imm_sel = rv_pkg::imm_i;
            rv_pkg::opc_load[6:2]:      imm_sel = rv_pkg::imm_i;
            rv_pkg::opc_jalr[6:2]:      imm_sel = rv_pkg::imm_i;
            rv_pkg::opc_fp_load[6:2]:   imm_sel = rv_pkg::imm_i;
            rv_pkg::opc_store[6:2]:     imm_sel = rv_pkg::imm_s;
            rv_pkg::opc_fp_store[6:2]:  imm_sel = rv_pkg::imm_s;
            rv_pkg::opc_branch[6:2]:    imm_sel = rv_pkg::imm_b;
            rv_pkg::opc_jal[6:2]:       imm_sel = rv_pkg::imm_j;
            rv_pkg::opc_lui[6:2]:       imm_sel = rv_pkg::imm_u;
            rv_pkg::opc_auipc[6:2]:     imm_sel = rv_pkg::imm_u;
            rv_pkg::opc_csr[6:2]:       imm_sel = rv_pkg::imm_csr;
            default:                    imm_sel = rv_pkg::imm_none;
        endcase
    end

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // Major opcodes
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011;
    localparam logic [6:0] opc_ari_rtype = 7'b0110011;
    localparam logic [6:0] opc_csr       = 7'b1110011;
    localparam logic [6:0] opc_fp_load   = 7'b0000111;
    localparam logic [6:0] opc_fp_store  = 7'b0100111;
    localparam logic [6:0] opc_fp_madd   = 7'b1000011;
    localparam logic [6:0] opc_fp        = 7'b1010011;

    // Function codes
    localparam logic [2:0] fnc_csrrw       = 3'b001;
    localparam logic [6:0] fnc7_fp_add     = 7'b0000000;
    localparam logic [6:0] fnc7_fp_fsgnj_s = 7'b0010000;
    localparam logic [6:0] fnc7_fp_mv_x_w  = 7'b1110000;
    localparam logic [6:0] fnc7_fp_mv_w_x  = 7'b1111000;
    localparam logic [6:0] fnc7_fp_cvt_s_w = 7'b1101000;

    // Immediate formats
    typedef enum logic [2:0] {
        imm_i    = 3'd0,
        imm_s    = 3'd1,
        imm_b    = 3'd2,
        imm_j    = 3'd3,
        imm_u    = 3'd4,
        imm_csr  = 3'd5,
        imm_none = 3'd6
    } imm_sel_e;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // Register file payloads
    typedef logic [31:0] xword_t;
    typedef logic [31:0] fword_t;

    // Writeback strobe for either register file
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_write_s;

    // ID/EX pipeline register contents
    typedef struct packed {
        logic        valid;
        logic        fpu_valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] fs1_val;
        logic [31:0] fs2_val;
        logic [31:0] fs3_val;
        logic [31:0] imm;
    } id_ex_s;

endpackage
